//--- Bender.yml
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - pc_tracker.sv
  - instr_class_decode.sv
  - imm_gen.sv
  - uop_decode.sv
  - decode_top.sv
  - target: test
    files:
      - decode_checker.sv
      - tb_decode.sv

//--- build.f
decode_pkg.sv
pc_tracker.sv
instr_class_decode.sv
imm_gen.sv
uop_decode.sv
decode_top.sv
decode_checker.sv
tb_decode.sv

//--- decode_checker.sv
// ------------------------------
// Decode stage checker
// Keeps a model PC and compares DUT outputs with the expected row
// ------------------------------
`timescale 1ns/1ps

module decode_checker #(
    parameter logic [31:0] pc_reset_addr = 32'h1000_0000
) (
    input  logic          g_clk,
    input  logic          g_resetn,
    input  logic          active_i,      // A row is being applied
    input  logic [95:0]   name_i,
    input  logic [31:0]   instr_i,
    input  logic          valid_i,
    input  logic          ready_i,
    input  logic [31:0]   target_i,
    input  logic [31:0]   rs1_data_i,
    input  logic [31:0]   rs2_data_i,
    input  logic [4:0]    exp_rd_i,
    input  logic [4:0]    exp_rs1_i,
    input  logic [4:0]    exp_rs2_i,
    input  logic [31:0]   exp_imm_i,
    input  logic [3:0]    exp_alu_i,
    input  logic [3:0]    exp_cfu_i,
    input  logic [5:0]    exp_lsu_i,     // load, store, byte, half, word, sext
    input  logic [2:0]    exp_wb_i,      // alu, lsu, npc
    input  logic          exp_trap_i,
    input  logic [6:0]    exp_cause_i,
    input  logic [1:0]    exp_pc_act_i,  // 0 hold, 1 step, 2 redirect
    input  logic [1:0]    lhs_sel_i,     // 0 rs1, 1 pc, 2 zero
    input  logic          rhs_imm_i,
    input  logic          sh_imm_i,
    input  logic          eat_i,
    input  logic          s2_valid_i,
    input  logic [4:0]    rd_i,
    input  logic [4:0]    rs1_addr_i,
    input  logic [4:0]    rs2_addr_i,
    input  logic [31:0]   pc_i,
    input  logic [31:0]   npc_i,
    input  logic [31:0]   imm_i,
    input  logic [31:0]   lhs_i,
    input  logic [31:0]   rhs_i,
    input  logic [31:0]   rs2_fwd_i,
    input  logic [4:0]    shamt_i,
    input  logic [3:0]    alu_op_i,
    input  logic [3:0]    cfu_op_i,
    input  logic [5:0]    lsu_i,
    input  logic [2:0]    wb_i,
    input  logic          trap_i,
    input  logic [6:0]    cause_i,
    output logic [31:0]   err_count_o,
    output logic [31:0]   check_count_o
);

    logic [31:0] model_pc;
    logic [31:0] exp_lhs;
    logic [31:0] exp_rhs;
    logic [4:0]  exp_shamt;

    initial begin
        err_count_o   = 0;
        check_count_o = 0;
    end

    task automatic compare(input string label, input logic [31:0] exp, input logic [31:0] act);
        check_count_o = check_count_o + 1;
        if (exp !== act) begin
            err_count_o = err_count_o + 1;
            $display("Fail %s %s: expected %h, actual %h", name_i, label, exp, act);
        end
    endtask

    // Model PC follows the action of the row that was live at this edge
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            model_pc <= pc_reset_addr;
        end else if (active_i) begin
            case (exp_pc_act_i)
                2'd1:    model_pc <= model_pc + 32'd4;
                2'd2:    model_pc <= target_i;
                default: model_pc <= model_pc;
            endcase
        end
    end

    // Outputs are combinational, so mid-cycle they have settled
    always @(negedge g_clk) begin
        if (active_i) begin
            exp_lhs   = (lhs_sel_i == 2'd1) ? model_pc :
                        (lhs_sel_i == 2'd2) ? 32'd0 : rs1_data_i;
            exp_rhs   = rhs_imm_i ? exp_imm_i : rs2_data_i;
            exp_shamt = sh_imm_i ? instr_i[24:20] : rs2_data_i[4:0];
            compare("eat", 32'(valid_i && ready_i), 32'(eat_i));
            compare("s2_valid", 32'(valid_i), 32'(s2_valid_i));
            compare("pc", model_pc, pc_i);
            compare("npc", model_pc + 32'd4, npc_i);
            compare("rd", 32'(exp_rd_i), 32'(rd_i));
            compare("rs1_addr", 32'(exp_rs1_i), 32'(rs1_addr_i));
            compare("rs2_addr", 32'(exp_rs2_i), 32'(rs2_addr_i));
            compare("imm", exp_imm_i, imm_i);
            compare("alu_op", 32'(exp_alu_i), 32'(alu_op_i));
            compare("cfu_op", 32'(exp_cfu_i), 32'(cfu_op_i));
            compare("alu_lhs", exp_lhs, lhs_i);
            compare("alu_rhs", exp_rhs, rhs_i);
            compare("shamt", 32'(exp_shamt), 32'(shamt_i));
            compare("rs2_data", rs2_data_i, rs2_fwd_i);
            compare("lsu", 32'(exp_lsu_i), 32'(lsu_i));
            compare("wb", 32'(exp_wb_i), 32'(wb_i));
            compare("trap", 32'(exp_trap_i), 32'(trap_i));
            compare("cause", 32'(exp_cause_i), 32'(cause_i));
        end
    end

endmodule

//--- decode_pkg.sv
// ------------------------------
// Decode stage shared types
// Data widths, opcode classes, ALU and control-flow operation codes
// and trap causes used across the RV32I decode stage
// ------------------------------
package decode_pkg;

    typedef logic [31:0] word_t;       // Instruction, data, immediate
    typedef logic [4:0]  reg_addr_t;   // GPR index
    typedef logic [6:0]  trap_cause_t;
    typedef logic [1:0]  ferr_t;       // One bit per 16-bit half

    // Major opcodes of the RV32I base set
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic [3:0] {
        cfu_none,
        cfu_beq,
        cfu_bne,
        cfu_blt,
        cfu_bge,
        cfu_bltu,
        cfu_bgeu,
        cfu_jal,
        cfu_jalr,
        cfu_ecall,
        cfu_ebreak
    } cfu_op_t;

    // ------------------------------
    // Trap causes

    localparam trap_cause_t trap_iaccess = 7'd1;  // Fetch bus error
    localparam trap_cause_t trap_iopcode = 7'd2;  // Illegal instruction

endpackage

//--- decode_top.sv
// ------------------------------
// Decode stage top level
// PC tracking, instruction classification, immediate generation
// and micro-op decode for one RV32I instruction at a time
// ------------------------------
`timescale 1ns/1ps

module decode_top #(
    parameter decode_pkg::word_t pc_reset_addr = 32'h1000_0000,
    parameter int unsigned       mem_addr_w    = 32
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,

    input  logic                    s1_valid_i,
    input  decode_pkg::word_t       s1_instr_i,
    input  decode_pkg::ferr_t       s1_ferr_i,
    output logic                    s1_eat_o,

    input  logic                    cf_valid_i,
    input  logic                    cf_ack_i,
    input  decode_pkg::word_t       cf_target_i,

    output decode_pkg::reg_addr_t   s1_rs1_addr_o,
    input  decode_pkg::word_t       s1_rs1_data_i,   // Forwarded
    output decode_pkg::reg_addr_t   s1_rs2_addr_o,
    input  decode_pkg::word_t       s1_rs2_data_i,   // Forwarded

    input  logic                    s2_ready_i,
    output logic                    s2_valid_o,
    output decode_pkg::reg_addr_t   s2_rd_o,
    output decode_pkg::word_t       s2_pc_o,
    output decode_pkg::word_t       s2_npc_o,
    output decode_pkg::word_t       s2_imm_o,
    output decode_pkg::word_t       s2_alu_lhs_o,
    output decode_pkg::word_t       s2_alu_rhs_o,
    output decode_pkg::word_t       s2_rs2_data_o,
    output logic [4:0]              s2_alu_shamt_o,
    output decode_pkg::alu_op_t     s2_alu_op_o,
    output decode_pkg::cfu_op_t     s2_cfu_op_o,

    output logic                    s2_lsu_load_o,
    output logic                    s2_lsu_store_o,
    output logic                    s2_lsu_byte_o,
    output logic                    s2_lsu_half_o,
    output logic                    s2_lsu_word_o,
    output logic                    s2_lsu_sext_o,

    output logic                    s2_wb_alu_o,
    output logic                    s2_wb_lsu_o,
    output logic                    s2_wb_npc_o,

    output logic                    s2_trap_o,
    output decode_pkg::trap_cause_t s2_trap_cause_o
);

    decode_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic                funct7_bit;
    logic [4:0]          shamt;

    assign s2_rs2_data_o = s1_rs2_data_i;  // Store data for the LSU

    pc_tracker #(
        .pc_reset_addr (pc_reset_addr),
        .mem_addr_w    (mem_addr_w)
    ) i_pc_tracker (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s1_valid_i  (s1_valid_i),
        .s2_ready_i  (s2_ready_i),
        .cf_valid_i  (cf_valid_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .s1_eat_o    (s1_eat_o),
        .s2_valid_o  (s2_valid_o),
        .pc_o        (s2_pc_o),
        .npc_o       (s2_npc_o)
    );

    instr_class_decode i_instr_class_decode (
        .s1_instr_i   (s1_instr_i),
        .s1_ferr_i    (s1_ferr_i),
        .opcode_o     (opcode),
        .funct3_o     (funct3),
        .funct7_bit_o (funct7_bit),
        .rs1_addr_o   (s1_rs1_addr_o),
        .rs2_addr_o   (s1_rs2_addr_o),
        .rd_o         (s2_rd_o),
        .trap_o       (s2_trap_o),
        .trap_cause_o (s2_trap_cause_o)
    );

    imm_gen i_imm_gen (
        .s1_instr_i (s1_instr_i),
        .opcode_i   (opcode),
        .imm_o      (s2_imm_o),
        .shamt_o    (shamt)
    );

    uop_decode i_uop_decode (
        .opcode_i     (opcode),
        .funct3_i     (funct3),
        .funct7_bit_i (funct7_bit),
        .imm_i        (s2_imm_o),
        .shamt_i      (shamt),
        .pc_i         (s2_pc_o),
        .rs1_data_i   (s1_rs1_data_i),
        .rs2_data_i   (s1_rs2_data_i),
        .trap_i       (s2_trap_o),
        .alu_op_o     (s2_alu_op_o),
        .cfu_op_o     (s2_cfu_op_o),
        .alu_lhs_o    (s2_alu_lhs_o),
        .alu_rhs_o    (s2_alu_rhs_o),
        .alu_shamt_o  (s2_alu_shamt_o),
        .lsu_load_o   (s2_lsu_load_o),
        .lsu_store_o  (s2_lsu_store_o),
        .lsu_byte_o   (s2_lsu_byte_o),
        .lsu_half_o   (s2_lsu_half_o),
        .lsu_word_o   (s2_lsu_word_o),
        .lsu_sext_o   (s2_lsu_sext_o),
        .wb_alu_o     (s2_wb_alu_o),
        .wb_lsu_o     (s2_wb_lsu_o),
        .wb_npc_o     (s2_wb_npc_o)
    );

endmodule

//--- imm_gen.sv
// ------------------------------
// Immediate generator
// Builds the sign-extended I, S, B, U and J immediates
// ------------------------------
`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::word_t   s1_instr_i,
    input  decode_pkg::opcode_t opcode_i,
    output decode_pkg::word_t   imm_o,
    output logic [4:0]          shamt_o
);

    decode_pkg::word_t imm_i;
    decode_pkg::word_t imm_s;
    decode_pkg::word_t imm_b;
    decode_pkg::word_t imm_u;
    decode_pkg::word_t imm_j;
    logic              sign;

    assign sign = s1_instr_i[31];

    assign imm_i = {{20{sign}}, s1_instr_i[31:20]};
    assign imm_s = {{20{sign}}, s1_instr_i[31:25], s1_instr_i[11:7]};
    assign imm_b = {{19{sign}}, sign, s1_instr_i[7], s1_instr_i[30:25],
                    s1_instr_i[11:8], 1'b0};
    assign imm_u = {s1_instr_i[31:12], 12'b0};
    assign imm_j = {{11{sign}}, sign, s1_instr_i[19:12], s1_instr_i[20],
                    s1_instr_i[30:21], 1'b0};

    assign shamt_o = s1_instr_i[24:20];  // Immediate shift amount

    always_comb begin
        case (opcode_i)
            decode_pkg::op_load,
            decode_pkg::op_imm,
            decode_pkg::op_jalr:   imm_o = imm_i;
            decode_pkg::op_store:  imm_o = imm_s;
            decode_pkg::op_branch: imm_o = imm_b;
            decode_pkg::op_lui,
            decode_pkg::op_auipc:  imm_o = imm_u;
            decode_pkg::op_jal:    imm_o = imm_j;
            default:               imm_o = 32'd0;
        endcase
    end

endmodule

//--- instr_class_decode.sv
// ------------------------------
// Instruction class decoder
// Maps the major opcode to a class, pulls out register fields
// and raises fetch-error and illegal-instruction traps
// ------------------------------
`timescale 1ns/1ps

module instr_class_decode (
    input  decode_pkg::word_t       s1_instr_i,
    input  decode_pkg::ferr_t       s1_ferr_i,
    output decode_pkg::opcode_t     opcode_o,
    output logic [2:0]              funct3_o,
    output logic                    funct7_bit_o,   // Bit 30 selects sub or sra
    output decode_pkg::reg_addr_t   rs1_addr_o,
    output decode_pkg::reg_addr_t   rs2_addr_o,
    output decode_pkg::reg_addr_t   rd_o,
    output logic                    trap_o,
    output decode_pkg::trap_cause_t trap_cause_o
);

    logic [6:0] funct7;
    logic       illegal;
    logic       iaccess;
    logic       zero_rd;

    assign opcode_o     = decode_pkg::opcode_t'(s1_instr_i[6:0]);
    assign funct3_o     = s1_instr_i[14:12];
    assign funct7       = s1_instr_i[31:25];
    assign funct7_bit_o = s1_instr_i[30];

    assign rs1_addr_o = s1_instr_i[19:15];
    assign rs2_addr_o = s1_instr_i[24:20];

    // Stores and branches have no destination
    assign zero_rd = (opcode_o == decode_pkg::op_store) ||
                     (opcode_o == decode_pkg::op_branch);
    assign rd_o    = zero_rd ? 5'd0 : s1_instr_i[11:7];

    // ------------------------------
    // Illegal encodings

    always_comb begin
        illegal = 1'b0;
        case (opcode_o)
            decode_pkg::op_load:   illegal = (funct3_o == 3'd3) || (funct3_o > 3'd5);
            decode_pkg::op_store:  illegal = (funct3_o > 3'd2);
            decode_pkg::op_branch: illegal = (funct3_o[2:1] == 2'b01);  // f3 of 2 and 3
            decode_pkg::op_jalr:   illegal = (funct3_o != 3'd0);
            decode_pkg::op_imm: begin
                if (funct3_o == 3'd1) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3_o == 3'd5) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            decode_pkg::op_reg: begin
                // Alternate encoding only exists for sub and sra
                illegal = !((funct7 == 7'b0000000) ||
                            ((funct7 == 7'b0100000) &&
                             ((funct3_o == 3'd0) || (funct3_o == 3'd5))));
            end
            decode_pkg::op_system: begin
                illegal = (s1_instr_i != 32'h0000_0073) &&   // ecall
                          (s1_instr_i != 32'h0010_0073);     // ebreak
            end
            decode_pkg::op_lui,
            decode_pkg::op_auipc,
            decode_pkg::op_jal:    illegal = 1'b0;
            default:               illegal = 1'b1;
        endcase
    end

    // ------------------------------
    // Traps

    assign iaccess = |s1_ferr_i;  // Either half faulted
    assign trap_o  = iaccess || illegal;

    assign trap_cause_o = iaccess ? decode_pkg::trap_iaccess :
                          illegal ? decode_pkg::trap_iopcode :
                                    7'd0;

endmodule

//--- pc_tracker.sv
// ------------------------------
// Program counter tracker
// Holds the decode PC, steps it by 4 on consume and
// takes control-flow redirects with priority
// ------------------------------
`timescale 1ns/1ps

module pc_tracker #(
    parameter decode_pkg::word_t pc_reset_addr = 32'h1000_0000,
    parameter int unsigned       mem_addr_w    = 32
) (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              s1_valid_i,
    input  logic              s2_ready_i,
    input  logic              cf_valid_i,
    input  logic              cf_ack_i,
    input  decode_pkg::word_t cf_target_i,
    output logic              s1_eat_o,
    output logic              s2_valid_o,
    output decode_pkg::word_t pc_o,
    output decode_pkg::word_t npc_o
);

    // Only as many bits as the physical memory address needs
    logic [mem_addr_w-1:0] pc_q;
    logic                  cf_change;

    assign cf_change  = cf_valid_i && cf_ack_i;

    assign s1_eat_o   = s1_valid_i && s2_ready_i;  // Instruction consumed
    assign s2_valid_o = s1_valid_i;

    assign pc_o  = decode_pkg::word_t'(pc_q);  // Upper bits read as zero
    assign npc_o = pc_o + 32'd4;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= pc_reset_addr[mem_addr_w-1:0];
        end else if (cf_change) begin
            pc_q <= cf_target_i[mem_addr_w-1:0];  // Redirect wins
        end else if (s1_eat_o) begin
            pc_q <= npc_o[mem_addr_w-1:0];
        end
    end

    // ------------------------------
    // Handshake check

    // Fetch keeps an instruction offered until it is consumed or flushed
    a_valid_held: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (s1_valid_i && !s1_eat_o && !cf_change) |=> s1_valid_i
    ) else $error("Fetch dropped s1_valid before the instruction was consumed");

endmodule

//--- tb_decode.sv
// ------------------------------
// Decode stage testbench
// Applies a table of instructions and handshake settings
// ------------------------------
`timescale 1ns/1ps

module tb_decode;

    localparam logic [31:0] reset_pc = 32'h1000_0000;
    localparam int          n_rows   = 21;
    localparam int          limit    = (n_rows + 4) * 4;  // Cycle budget

    logic g_clk;
    logic g_resetn;
    logic s1_valid, s2_ready, cf_valid, cf_ack, active;
    logic [31:0] s1_instr, cf_target, rs1_data, rs2_data;
    logic [1:0]  s1_ferr;
    logic        eat, s2_valid, lsu_ld, lsu_st, lsu_b, lsu_h, lsu_w, lsu_sx;
    logic        wb_alu, wb_lsu, wb_npc, trap;
    logic [4:0]  rs1_addr, rs2_addr, rd, shamt;
    logic [31:0] pc, npc, imm, lhs, rhs, rs2_fwd, err_count, check_count;
    logic [3:0]  alu_op, cfu_op;
    logic [6:0]  cause;
    int          cycles;
    int          row_cnt;

    // ------------------------------
    // Stimulus table
    logic [95:0] t_name [n_rows];
    logic [31:0] t_instr [n_rows];
    logic [31:0] t_target [n_rows];
    logic [31:0] t_imm [n_rows];
    logic [1:0]  t_ferr [n_rows];
    logic [2:0]  t_hs [n_rows];        // ready, cf_valid, cf_ack
    logic [14:0] t_regs [n_rows];      // rd, rs1, rs2
    logic [7:0]  t_ops [n_rows];       // alu, cfu
    logic [5:0]  t_lsu [n_rows];
    logic [2:0]  t_wb [n_rows];
    logic [7:0]  t_trap [n_rows];      // trap, cause
    logic [5:0]  t_sel [n_rows];       // pc action, lhs sel, rhs imm, shamt imm

    // Row columns are name, instr, ferr, handshake, target, regs, imm, alu, cfu,
    // lsu, wb, trap+cause, pc action, lhs, rhs and shamt source
    task automatic add_row(input logic [95:0] name, input logic [31:0] instr,
                           input logic [1:0] ferr, input logic [2:0] hs,
                           input logic [31:0] target, input logic [14:0] regs,
                           input logic [31:0] imm_v, input logic [3:0] alu,
                           input logic [3:0] cfu, input logic [5:0] lsu,
                           input logic [2:0] wb, input logic [7:0] trp,
                           input logic [1:0] pc_act, input logic [1:0] lhs_sel,
                           input logic rhs_sel, input logic sh_sel);
        t_name[row_cnt]   = name;
        t_instr[row_cnt]  = instr;
        t_ferr[row_cnt]   = ferr;
        t_hs[row_cnt]     = hs;
        t_target[row_cnt] = target;
        t_regs[row_cnt]   = regs;
        t_imm[row_cnt]    = imm_v;
        t_ops[row_cnt]    = {alu, cfu};
        t_lsu[row_cnt]    = lsu;
        t_wb[row_cnt]     = wb;
        t_trap[row_cnt]   = trp;
        t_sel[row_cnt]    = {pc_act, lhs_sel, rhs_sel, sh_sel};
        row_cnt = row_cnt + 1;
    endtask

    task automatic fill_table();
        add_row("addi", 32'h00510093, 2'b00, 3'b100, 0, {5'd1, 5'd2, 5'd5}, 32'd5,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 1, 0, 1, 1);
        add_row("add", 32'h005201B3, 2'b00, 3'b100, 0, {5'd3, 5'd4, 5'd5}, 32'd0,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 1, 0, 0, 0);
        add_row("sub", 32'h40838333, 2'b00, 3'b100, 0, {5'd6, 5'd7, 5'd8}, 32'd0,
                decode_pkg::alu_sub, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 1, 0, 0, 0);
        add_row("lui", 32'h123454B7, 2'b00, 3'b100, 0, {5'd9, 5'd8, 5'd3}, 32'h12345000,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 1, 2, 1, 0);
        add_row("auipc", 32'h00001517, 2'b00, 3'b100, 0, {5'd10, 5'd0, 5'd0}, 32'h1000,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 1, 1, 1, 0);
        add_row("slli", 32'h00361593, 2'b00, 3'b100, 0, {5'd11, 5'd12, 5'd3}, 32'd3,
                decode_pkg::alu_sll, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 1, 0, 1, 1);
        add_row("add_hold", 32'h005201B3, 2'b00, 3'b000, 0, {5'd3, 5'd4, 5'd5}, 32'd0,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 0, 0, 0, 0);
        add_row("add_hold2", 32'h005201B3, 2'b00, 3'b000, 0, {5'd3, 5'd4, 5'd5}, 32'd0,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0, 0, 0, 0, 0);
        add_row("lw", 32'h00872683, 2'b00, 3'b100, 0, {5'd13, 5'd14, 5'd8}, 32'd8,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b100011, 3'b010, 8'h0, 1, 0, 1, 0);
        add_row("lb", 32'hFFF08783, 2'b00, 3'b100, 0, {5'd15, 5'd1, 5'd31}, 32'hFFFFFFFF,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b101001, 3'b010, 8'h0, 1, 0, 1, 0);
        add_row("sb", 32'h00218223, 2'b00, 3'b100, 0, {5'd0, 5'd3, 5'd2}, 32'd4,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b011000, 3'b000, 8'h0, 1, 0, 1, 0);
        add_row("sw", 32'hFE532E23, 2'b00, 3'b100, 0, {5'd0, 5'd6, 5'd5}, 32'hFFFFFFFC,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b010010, 3'b000, 8'h0, 1, 0, 1, 0);
        add_row("beq", 32'h00208463, 2'b00, 3'b100, 0, {5'd0, 5'd1, 5'd2}, 32'd8,
                decode_pkg::alu_sub, decode_pkg::cfu_beq, 6'b0, 3'b000, 8'h0, 1, 0, 0, 0);
        add_row("bltu", 32'hFE41E8E3, 2'b00, 3'b100, 0, {5'd0, 5'd3, 5'd4}, 32'hFFFFFFF0,
                decode_pkg::alu_sub, decode_pkg::cfu_bltu, 6'b0, 3'b000, 8'h0, 1, 0, 0, 0);
        // Redirect taken while the instruction is also consumed
        add_row("jal_redir", 32'h001000EF, 2'b00, 3'b111, 32'h10000200, {5'd1, 5'd0, 5'd1},
                32'h800, decode_pkg::alu_none, decode_pkg::cfu_jal, 6'b0, 3'b001, 8'h0,
                2, 0, 0, 0);
        add_row("jalr", 32'h00C28067, 2'b00, 3'b100, 0, {5'd0, 5'd5, 5'd12}, 32'd12,
                decode_pkg::alu_none, decode_pkg::cfu_jalr, 6'b0, 3'b001, 8'h0, 1, 0, 0, 0);
        add_row("ecall", 32'h00000073, 2'b00, 3'b100, 0, {5'd0, 5'd0, 5'd0}, 32'd0,
                decode_pkg::alu_none, decode_pkg::cfu_ecall, 6'b0, 3'b000, 8'h0, 1, 0, 0, 0);
        add_row("ebreak", 32'h00100073, 2'b00, 3'b100, 0, {5'd0, 5'd0, 5'd1}, 32'd0,
                decode_pkg::alu_none, decode_pkg::cfu_ebreak, 6'b0, 3'b000, 8'h0, 1, 0, 0, 0);
        add_row("lw_ferr", 32'h00872683, 2'b01, 3'b100, 0, {5'd13, 5'd14, 5'd8}, 32'd8,
                decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b000, 8'h81, 1, 0, 1, 0);
        add_row("bad_op", 32'h0000007F, 2'b00, 3'b100, 0, {5'd0, 5'd0, 5'd0}, 32'd0,
                decode_pkg::alu_none, decode_pkg::cfu_none, 6'b0, 3'b000, 8'h82, 1, 0, 0, 0);
        add_row("cf_no_ack", 32'h005201B3, 2'b00, 3'b110, 32'h20000000, {5'd3, 5'd4, 5'd5},
                32'd0, decode_pkg::alu_add, decode_pkg::cfu_none, 6'b0, 3'b100, 8'h0,
                1, 0, 0, 0);
    endtask

    decode_top #(
        .pc_reset_addr (reset_pc),
        .mem_addr_w    (32)
    ) i_dut (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .s1_valid_i (s1_valid), .s1_instr_i (s1_instr), .s1_ferr_i (s1_ferr),
        .s1_eat_o (eat), .cf_valid_i (cf_valid), .cf_ack_i (cf_ack),
        .cf_target_i (cf_target), .s1_rs1_addr_o (rs1_addr), .s1_rs1_data_i (rs1_data),
        .s1_rs2_addr_o (rs2_addr), .s1_rs2_data_i (rs2_data), .s2_ready_i (s2_ready),
        .s2_valid_o (s2_valid), .s2_rd_o (rd), .s2_pc_o (pc), .s2_npc_o (npc),
        .s2_imm_o (imm), .s2_alu_lhs_o (lhs), .s2_alu_rhs_o (rhs),
        .s2_rs2_data_o (rs2_fwd), .s2_alu_shamt_o (shamt), .s2_alu_op_o (alu_op),
        .s2_cfu_op_o (cfu_op), .s2_lsu_load_o (lsu_ld), .s2_lsu_store_o (lsu_st),
        .s2_lsu_byte_o (lsu_b), .s2_lsu_half_o (lsu_h), .s2_lsu_word_o (lsu_w),
        .s2_lsu_sext_o (lsu_sx), .s2_wb_alu_o (wb_alu), .s2_wb_lsu_o (wb_lsu),
        .s2_wb_npc_o (wb_npc), .s2_trap_o (trap), .s2_trap_cause_o (cause)
    );

    logic [95:0] cur_name;
    logic [31:0] cur_imm;
    logic [14:0] cur_regs;
    logic [7:0]  cur_ops, cur_trap;
    logic [5:0]  cur_lsu, cur_sel;
    logic [2:0]  cur_wb;

    decode_checker #(.pc_reset_addr (reset_pc)) i_checker (
        .g_clk (g_clk), .g_resetn (g_resetn), .active_i (active), .name_i (cur_name),
        .instr_i (s1_instr), .valid_i (s1_valid), .ready_i (s2_ready),
        .target_i (cf_target), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .exp_rd_i (cur_regs[14:10]), .exp_rs1_i (cur_regs[9:5]), .exp_rs2_i (cur_regs[4:0]),
        .exp_imm_i (cur_imm), .exp_alu_i (cur_ops[7:4]), .exp_cfu_i (cur_ops[3:0]),
        .exp_lsu_i (cur_lsu), .exp_wb_i (cur_wb), .exp_trap_i (cur_trap[7]),
        .exp_cause_i (cur_trap[6:0]), .exp_pc_act_i (cur_sel[5:4]),
        .lhs_sel_i (cur_sel[3:2]), .rhs_imm_i (cur_sel[1]), .sh_imm_i (cur_sel[0]),
        .eat_i (eat), .s2_valid_i (s2_valid), .rd_i (rd), .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr), .pc_i (pc), .npc_i (npc), .imm_i (imm), .lhs_i (lhs),
        .rhs_i (rhs), .rs2_fwd_i (rs2_fwd), .shamt_i (shamt), .alu_op_i (alu_op),
        .cfu_op_i (cfu_op), .lsu_i ({lsu_ld, lsu_st, lsu_b, lsu_h, lsu_w, lsu_sx}),
        .wb_i ({wb_alu, wb_lsu, wb_npc}), .trap_i (trap), .cause_i (cause),
        .err_count_o (err_count), .check_count_o (check_count)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    // Run length guard
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(64));
        cycles = 0;
        row_cnt = 0;
        g_resetn = 1'b0;
        s1_valid = 1'b0;
        s1_instr = '0;
        s1_ferr = '0;
        s2_ready = 1'b0;
        cf_valid = 1'b0;
        cf_ack = 1'b0;
        cf_target = '0;
        rs1_data = '0;
        rs2_data = '0;
        active = 1'b0;
        cur_name = '0;
        cur_imm = '0;
        cur_regs = '0;
        cur_ops = '0;
        cur_trap = '0;
        cur_lsu = '0;
        cur_sel = '0;
        cur_wb = '0;
        fill_table();
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge g_clk);
            s1_valid  <= 1'b1;
            s1_instr  <= t_instr[i];
            s1_ferr   <= t_ferr[i];
            {s2_ready, cf_valid, cf_ack} <= t_hs[i];
            cf_target <= t_target[i];
            rs1_data  <= $urandom;
            rs2_data  <= $urandom;
            cur_name  <= t_name[i];
            cur_imm   <= t_imm[i];
            cur_regs  <= t_regs[i];
            cur_ops   <= t_ops[i];
            cur_lsu   <= t_lsu[i];
            cur_wb    <= t_wb[i];
            cur_trap  <= t_trap[i];
            cur_sel   <= t_sel[i];
            active    <= 1'b1;
        end
        @(posedge g_clk);
        active   <= 1'b0;
        s1_valid <= 1'b0;
        @(negedge g_clk);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- uop_decode.sv
// ------------------------------
// Micro-op decoder
// ALU, control-flow, load/store and writeback control plus
// ALU operand selection
// ------------------------------
`timescale 1ns/1ps

module uop_decode (
    input  decode_pkg::opcode_t opcode_i,
    input  logic [2:0]          funct3_i,
    input  logic                funct7_bit_i,
    input  decode_pkg::word_t   imm_i,
    input  logic [4:0]          shamt_i,
    input  decode_pkg::word_t   pc_i,
    input  decode_pkg::word_t   rs1_data_i,
    input  decode_pkg::word_t   rs2_data_i,
    input  logic                trap_i,
    output decode_pkg::alu_op_t alu_op_o,
    output decode_pkg::cfu_op_t cfu_op_o,
    output decode_pkg::word_t   alu_lhs_o,
    output decode_pkg::word_t   alu_rhs_o,
    output logic [4:0]          alu_shamt_o,
    output logic                lsu_load_o,
    output logic                lsu_store_o,
    output logic                lsu_byte_o,
    output logic                lsu_half_o,
    output logic                lsu_word_o,
    output logic                lsu_sext_o,
    output logic                wb_alu_o,
    output logic                wb_lsu_o,
    output logic                wb_npc_o
);

    logic is_load;
    logic is_store;
    logic is_imm;
    logic is_reg;
    logic is_lui;
    logic is_auipc;
    logic mem_op;

    assign is_load  = (opcode_i == decode_pkg::op_load);
    assign is_store = (opcode_i == decode_pkg::op_store);
    assign is_imm   = (opcode_i == decode_pkg::op_imm);
    assign is_reg   = (opcode_i == decode_pkg::op_reg);
    assign is_lui   = (opcode_i == decode_pkg::op_lui);
    assign is_auipc = (opcode_i == decode_pkg::op_auipc);

    // ------------------------------
    // ALU operands

    assign alu_lhs_o = is_auipc ? pc_i  :
                       is_lui   ? 32'd0 :
                                  rs1_data_i;

    assign alu_rhs_o = (is_imm || is_lui || is_auipc || is_load || is_store) ?
                       imm_i : rs2_data_i;

    assign alu_shamt_o = is_imm ? shamt_i : rs2_data_i[4:0];

    always_comb begin
        alu_op_o = decode_pkg::alu_none;
        if (is_imm || is_reg) begin
            case (funct3_i)
                3'd0: begin
                    if (is_reg && funct7_bit_i) begin
                        alu_op_o = decode_pkg::alu_sub;
                    end else begin
                        alu_op_o = decode_pkg::alu_add;
                    end
                end
                3'd1: alu_op_o = decode_pkg::alu_sll;
                3'd2: alu_op_o = decode_pkg::alu_slt;
                3'd3: alu_op_o = decode_pkg::alu_sltu;
                3'd4: alu_op_o = decode_pkg::alu_xor;
                3'd5: begin
                    if (funct7_bit_i) begin
                        alu_op_o = decode_pkg::alu_sra;
                    end else begin
                        alu_op_o = decode_pkg::alu_srl;
                    end
                end
                3'd6: alu_op_o = decode_pkg::alu_or;
                default: alu_op_o = decode_pkg::alu_and;
            endcase
        end else if (opcode_i == decode_pkg::op_branch) begin
            alu_op_o = decode_pkg::alu_sub;  // Compare by subtraction
        end else if (is_load || is_store || is_lui || is_auipc) begin
            alu_op_o = decode_pkg::alu_add;  // Address or upper-imm sum
        end
    end

    // ------------------------------
    // Control flow

    always_comb begin
        cfu_op_o = decode_pkg::cfu_none;
        case (opcode_i)
            decode_pkg::op_branch: begin
                case (funct3_i)
                    3'd0:    cfu_op_o = decode_pkg::cfu_beq;
                    3'd1:    cfu_op_o = decode_pkg::cfu_bne;
                    3'd4:    cfu_op_o = decode_pkg::cfu_blt;
                    3'd5:    cfu_op_o = decode_pkg::cfu_bge;
                    3'd6:    cfu_op_o = decode_pkg::cfu_bltu;
                    3'd7:    cfu_op_o = decode_pkg::cfu_bgeu;
                    default: cfu_op_o = decode_pkg::cfu_none;
                endcase
            end
            decode_pkg::op_jal:  cfu_op_o = decode_pkg::cfu_jal;
            decode_pkg::op_jalr: cfu_op_o = decode_pkg::cfu_jalr;
            decode_pkg::op_system: begin
                // I-type imm bit 0 splits ebreak from ecall
                if (shamt_i[0]) begin
                    cfu_op_o = decode_pkg::cfu_ebreak;
                end else begin
                    cfu_op_o = decode_pkg::cfu_ecall;
                end
            end
            default: cfu_op_o = decode_pkg::cfu_none;
        endcase
    end

    // ------------------------------
    // Load/store and writeback

    assign mem_op = (is_load || is_store) && !trap_i;

    assign lsu_load_o  = is_load && !trap_i;
    assign lsu_store_o = is_store && !trap_i;
    assign lsu_byte_o  = mem_op && (funct3_i[1:0] == 2'd0);
    assign lsu_half_o  = mem_op && (funct3_i[1:0] == 2'd1);
    assign lsu_word_o  = mem_op && (funct3_i[1:0] == 2'd2);
    assign lsu_sext_o  = lsu_load_o && !funct3_i[2];   // lbu/lhu zero extend

    assign wb_alu_o = (is_imm || is_reg || is_lui || is_auipc) && !trap_i;
    assign wb_lsu_o = lsu_load_o;
    assign wb_npc_o = ((opcode_i == decode_pkg::op_jal) ||
                       (opcode_i == decode_pkg::op_jalr)) && !trap_i;

    // Width encoding 3 must already have trapped as illegal
    a_mem_has_width: assert final (!mem_op || lsu_byte_o || lsu_half_o || lsu_word_o)
        else $error("Memory access decoded with no width");

endmodule
